// File: hw/core_pkg.sv
/*
  core package
  shared vector types and constants for the instruction fetch front end:
  register and instruction widths, the branch/jump control bus layout,
  the reset pc, the memory base address and the JAL opcode
*/
`default_nettype none

package core_pkg;

  // register-wide value, used for pcs and memory data
  typedef logic [63:0] reg_t;

  // one 32-bit instruction word
  typedef logic [31:0] inst_t;

  // major opcode field of an instruction
  typedef logic [6:0] opcode_t;

  // branch/jump control bus from decode back to fetch
  // target pc in 65:2, redirect enable in bit 1, valid in bit 0
  typedef logic [65:0] bj_bus_t;

  localparam int bj_valid_bit = 0;
  localparam int bj_ena_bit   = 1;
  localparam int bj_pc_lsb    = 2;

  // pc held after reset, so the first sequential fetch lands on mem_base
  localparam reg_t reset_pc = 64'h0000_0000_7fff_fffc;

  // byte address of memory word 0
  localparam reg_t mem_base = 64'h0000_0000_8000_0000;

  // sequential pc increment, one word
  localparam reg_t pc_step = 64'd4;

  localparam opcode_t opcode_jal = 7'b110_1111;

endpackage

`default_nettype wire

// File: hw/inst_mem.sv
/*
  instruction memory
  word-addressed array of instructions, filled through a load port.
  a request is answered after a fixed number of wait cycles; the read
  word is zero-extended to register width and addresses outside the
  array read as zero
*/
`default_nettype none

module inst_mem #(
  parameter int mem_words = 256,
  parameter int mem_wait  = 2,
  localparam int idx_w    = (mem_words > 1) ? $clog2(mem_words) : 1
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  mem_valid,
  input  wire core_pkg::reg_t  mem_addr,
  output logic                 mem_ready,
  output core_pkg::reg_t       mem_rdata,
  input  wire                  load_en,
  input  wire [idx_w-1:0]      load_index,
  input  wire core_pkg::inst_t load_data
);

  // counter must be able to hold mem_wait itself, also for a zero wait
  localparam int cnt_w = $clog2(mem_wait + 2);
  localparam logic [cnt_w-1:0] wait_last = cnt_w'(mem_wait);

  core_pkg::inst_t mem [mem_words];

  logic [cnt_w-1:0] wait_cnt;
  core_pkg::reg_t   offset;
  logic             in_range;

  // preload writes
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_index] <= load_data;
    end
  end

  // wait counter, runs while a request is pending
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (mem_valid && mem_ready) begin
      wait_cnt <= '0;
    end else if (mem_valid) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign mem_ready = mem_valid && (wait_cnt == wait_last);

  // byte offset into the array, low two bits ignored
  assign offset   = mem_addr - core_pkg::mem_base;
  assign in_range = (mem_addr >= core_pkg::mem_base) && (offset[63:2] < mem_words);

  always_comb begin
    mem_rdata = '0;
    if (in_range) begin
      mem_rdata = {32'b0, mem[offset[idx_w+1:2]]};
    end
  end

endmodule

`default_nettype wire

// File: hw/if_stage.sv
/*
  instruction fetch stage
  waits in idle for a next-pc decision from decode, requests one word
  from instruction memory, then holds the pc and instruction in the
  fetch register until decode takes them. the next pc is either the
  redirect target from the control bus or the last pc plus 4
*/
`default_nettype none

module if_stage (
  input  wire                  clk,
  input  wire                  rst,

  // toward decode
  output logic                 if_to_id_valid,
  output core_pkg::reg_t       if_to_id_pc,
  output core_pkg::inst_t      if_to_id_inst,
  input  wire                  id_allowin,

  // branch/jump control from decode
  output logic                 if_bj_ready,
  input  wire core_pkg::bj_bus_t bj_ctrl_bus,

  // instruction memory request port
  output logic                 mem_valid,
  input  wire                  mem_ready,
  input  wire core_pkg::reg_t  mem_rdata,
  output core_pkg::reg_t       mem_addr
);

  typedef enum logic [1:0] {
    s_idle,
    s_addr,
    s_retn
  } fetch_state_t;

  fetch_state_t state;
  fetch_state_t state_next;

  core_pkg::reg_t  bj_pc;
  logic            bj_ena;
  logic            bj_valid;
  logic            bj_handshake;
  logic            mem_handshake;

  logic            pre_to_if_valid;
  core_pkg::reg_t  next_pc;
  core_pkg::inst_t inst_buf;

  logic            if_valid;
  logic            if_allowin;
  logic            if_flush;
  core_pkg::reg_t  if_pc;
  core_pkg::inst_t if_inst;

  // unpack the control bus
  assign bj_pc    = bj_ctrl_bus[core_pkg::bj_pc_lsb +: $bits(core_pkg::reg_t)];
  assign bj_ena   = bj_ctrl_bus[core_pkg::bj_ena_bit];
  assign bj_valid = bj_ctrl_bus[core_pkg::bj_valid_bit];

  assign if_bj_ready   = (state == s_idle);
  assign bj_handshake  = if_bj_ready && bj_valid;

  assign mem_valid     = (state == s_addr);
  assign mem_handshake = mem_valid && mem_ready;

  // fetched word is ready to enter the fetch register
  assign pre_to_if_valid = (state == s_retn);

  assign next_pc = bj_ena ? bj_pc : (if_pc + core_pkg::pc_step);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      s_idle: begin
        if (bj_handshake) begin
          state_next = s_addr;
        end
      end
      s_addr: begin
        if (mem_handshake) begin
          state_next = s_retn;
        end
      end
      s_retn: begin
        // wait for the fetch register to drain
        if (pre_to_if_valid && if_allowin) begin
          state_next = s_idle;
        end
      end
      default: begin
        state_next = s_idle;
      end
    endcase
  end

  // pre-fetch address, follows next_pc while idle and is frozen after
  // the handshake so it stays stable during the request
  always_ff @(posedge clk) begin
    if (state == s_idle) begin
      mem_addr <= next_pc;
    end
  end

  // memory data is only valid in the transfer cycle
  always_ff @(posedge clk) begin
    if (mem_handshake) begin
      inst_buf <= mem_rdata[31:0];
    end
  end

  // fetch register
  assign if_flush       = bj_handshake && bj_ena;
  assign if_allowin     = !if_valid || id_allowin;
  assign if_to_id_valid = if_valid && !if_flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      if_valid <= 1'b0;
    end else if (if_flush) begin
      if_valid <= 1'b0;
    end else if (if_allowin) begin
      if_valid <= pre_to_if_valid;
    end
  end

  // if_pc also acts as the base for the sequential next pc
  always_ff @(posedge clk) begin
    if (rst) begin
      if_pc <= core_pkg::reset_pc;
    end else if (pre_to_if_valid && if_allowin) begin
      if_pc <= mem_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (pre_to_if_valid && if_allowin) begin
      if_inst <= inst_buf;
    end
  end

  assign if_to_id_pc   = if_pc;
  assign if_to_id_inst = if_inst;

endmodule

`default_nettype wire

// File: hw/id_stage.sv
/*
  instruction decode stage
  holds one instruction from fetch, recognises JAL and computes its
  target, and returns one next-pc decision per accepted instruction
  over the branch/jump control bus. a start token is sent once after
  reset. decoded instructions leave through the retire port, which
  can stall the stage
*/
`default_nettype none

module id_stage (
  input  wire                  clk,
  input  wire                  rst,

  // from fetch
  input  wire                  if_to_id_valid,
  input  wire core_pkg::reg_t  if_to_id_pc,
  input  wire core_pkg::inst_t if_to_id_inst,
  output logic                 id_allowin,

  // branch/jump control toward fetch
  input  wire                  if_bj_ready,
  output core_pkg::bj_bus_t    bj_ctrl_bus,

  // retire port
  output logic                 retire_valid,
  output core_pkg::reg_t       retire_pc,
  output core_pkg::inst_t      retire_inst,
  output logic                 retire_jump,
  input  wire                  retire_ready
);

  logic            id_valid;
  core_pkg::reg_t  id_pc;
  core_pkg::inst_t id_inst;

  logic            id_accept;
  logic            id_free;
  logic            id_is_jal;
  core_pkg::reg_t  jal_imm;
  core_pkg::reg_t  jal_target;

  logic            pending;
  logic            bj_raise;
  logic            bj_handshake;
  logic            bj_valid_q;
  logic            bj_ena_q;
  core_pkg::reg_t  bj_target_q;

  // register is empty or its instruction leaves this cycle
  assign id_free    = !id_valid || retire_ready;
  assign id_allowin = id_free && !pending;
  assign id_accept  = if_to_id_valid && id_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (id_accept) begin
      id_valid <= 1'b1;
    end else if (retire_ready) begin
      id_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (id_accept) begin
      id_pc   <= if_to_id_pc;
      id_inst <= if_to_id_inst;
    end
  end

  // JAL decode and J-type immediate
  assign id_is_jal = (id_inst[6:0] == core_pkg::opcode_jal);
  assign jal_imm   = {{43{id_inst[31]}}, id_inst[31], id_inst[19:12],
                      id_inst[20], id_inst[30:21], 1'b0};
  assign jal_target = id_pc + jal_imm;

  // one decision owed after reset and after each accepted instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b1;
    end else if (id_accept) begin
      pending <= 1'b1;
    end else if (bj_handshake) begin
      pending <= 1'b0;
    end
  end

  // hold the decision back while retire is stalled
  assign bj_raise     = pending && !bj_valid_q && id_free;
  assign bj_handshake = bj_valid_q && if_bj_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      bj_valid_q <= 1'b0;
      bj_ena_q   <= 1'b0;
    end else if (bj_handshake) begin
      bj_valid_q <= 1'b0;
    end else if (bj_raise) begin
      bj_valid_q <= 1'b1;
      // start token has no instruction behind it
      bj_ena_q   <= id_valid && id_is_jal;
    end
  end

  always_ff @(posedge clk) begin
    if (bj_raise) begin
      bj_target_q <= jal_target;
    end
  end

  always_comb begin
    bj_ctrl_bus = '0;
    bj_ctrl_bus[core_pkg::bj_pc_lsb +: $bits(core_pkg::reg_t)] = bj_target_q;
    bj_ctrl_bus[core_pkg::bj_ena_bit]   = bj_ena_q;
    bj_ctrl_bus[core_pkg::bj_valid_bit] = bj_valid_q;
  end

  assign retire_valid = id_valid;
  assign retire_pc    = id_pc;
  assign retire_inst  = id_inst;
  assign retire_jump  = id_is_jal;

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
/*
  fetch front end top level
  instruction memory, fetch stage and decode stage in a chain.
  memory depth and wait cycles are set here and passed to the memory
*/
`default_nettype none

module fetch_top #(
  parameter int mem_words = 256,
  parameter int mem_wait  = 2,
  localparam int idx_w    = (mem_words > 1) ? $clog2(mem_words) : 1
) (
  input  wire                  clk,
  input  wire                  rst,

  // preload port
  input  wire                  load_en,
  input  wire [idx_w-1:0]      load_index,
  input  wire core_pkg::inst_t load_data,

  // retire port
  output logic                 retire_valid,
  output core_pkg::reg_t       retire_pc,
  output core_pkg::inst_t      retire_inst,
  output logic                 retire_jump,
  input  wire                  retire_ready
);

  // memory request
  logic              mem_valid;
  logic              mem_ready;
  core_pkg::reg_t    mem_addr;
  core_pkg::reg_t    mem_rdata;

  // fetch to decode
  logic              if_to_id_valid;
  core_pkg::reg_t    if_to_id_pc;
  core_pkg::inst_t   if_to_id_inst;
  logic              id_allowin;

  // next-pc decision
  logic              if_bj_ready;
  core_pkg::bj_bus_t bj_ctrl_bus;

  inst_mem #(
    .mem_words (mem_words),
    .mem_wait  (mem_wait)
  ) u_inst_mem (
    .clk        (clk),
    .rst        (rst),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .load_en    (load_en),
    .load_index (load_index),
    .load_data  (load_data)
  );

  if_stage u_if_stage (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_inst  (if_to_id_inst),
    .id_allowin     (id_allowin),
    .if_bj_ready    (if_bj_ready),
    .bj_ctrl_bus    (bj_ctrl_bus),
    .mem_valid      (mem_valid),
    .mem_ready      (mem_ready),
    .mem_rdata      (mem_rdata),
    .mem_addr       (mem_addr)
  );

  id_stage u_id_stage (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_inst  (if_to_id_inst),
    .id_allowin     (id_allowin),
    .if_bj_ready    (if_bj_ready),
    .bj_ctrl_bus    (bj_ctrl_bus),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_inst    (retire_inst),
    .retire_jump    (retire_jump),
    .retire_ready   (retire_ready)
  );

endmodule

`default_nettype wire

// File: verification/tb_fetch_top.sv
/*
  testbench for the fetch front end
  preloads a 16-word program during reset, collects retires and checks
  them against a model of the program flow (pc + 4, or JAL target).
  covers reset, straight code, JAL jumps, back-pressure and retire rate
*/
`default_nettype none

module tb_fetch_top;

  localparam int mem_words = 256;
  localparam int mem_wait  = 2;
  localparam int idx_w     = $clog2(mem_words);
  localparam int prog_len  = 16;
  localparam int reset_cycles = 16;
  localparam int num_tests = 6;
  localparam int total_retires = 1 + 16 + 10 + 12 + 20 + 16;
  localparam int watchdog_cycles =
    total_retires * (mem_wait + 5) * 4 + num_tests * (reset_cycles + 1);
  localparam logic [63:0] base_pc = 64'h0000_0000_8000_0000;
  localparam logic [6:0]  jal_op  = 7'b110_1111;

  logic             clk;
  logic             rst;
  logic             load_en;
  logic [idx_w-1:0] load_index;
  logic [31:0]      load_data;
  logic             retire_valid;
  logic [63:0]      retire_pc;
  logic [31:0]      retire_inst;
  logic             retire_jump;
  logic             retire_ready;

  logic [31:0] prog [prog_len];
  int          errors;
  int          retire_count;
  integer      seed;

  fetch_top #(
    .mem_words (mem_words),
    .mem_wait  (mem_wait)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .load_en      (load_en),
    .load_index   (load_index),
    .load_data    (load_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_inst  (retire_inst),
    .retire_jump  (retire_jump),
    .retire_ready (retire_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // plain addi word that is never a jump
  function automatic logic [31:0] addi_word(input int k);
    logic [11:0] imm;
    logic [4:0]  rd;
    imm = k[11:0];
    rd  = k[4:0];
    return {imm, 5'd0, 3'b000, rd, 7'b001_0011};
  endfunction

  // jal x0 with a byte offset
  function automatic logic [31:0] jal_word(input int offset);
    logic [20:0] imm;
    imm = offset[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, jal_op};
  endfunction

  function automatic logic [63:0] j_offset(input logic [31:0] inst);
    return {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  function automatic void fill_straight(input int tag);
    for (int i = 0; i < prog_len; i++) begin
      prog[i] = addi_word(tag * 16 + i + 1);
    end
  endfunction

  // 16-cycle reset that writes one program word per cycle
  task automatic apply_reset();
    @(posedge clk);
    rst          <= 1'b1;
    retire_ready <= 1'b1;
    load_en      <= 1'b1;
    load_index   <= '0;
    load_data    <= prog[0];
    for (int i = 1; i < prog_len; i++) begin
      @(posedge clk);
      if (i >= 2) begin
        assert (retire_valid == 1'b0) else begin
          $display("Error: %0t retire_valid exp 0 got %b", $time, retire_valid);
          errors++;
        end
      end
      load_index <= idx_w'(i);
      load_data  <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
    rst     <= 1'b0;
  endtask

  // collect n retires and compare each with the program model
  task automatic collect(input int n, input bit backpressure, input bit check_rate);
    logic [63:0] pc;
    logic [31:0] exp_inst;
    logic        exp_jump;
    int          got;
    int          cycle;
    int          last_cycle;
    int          stretch;
    logic        level;
    pc         = base_pc;
    got        = 0;
    cycle      = 0;
    last_cycle = -1;
    stretch    = 0;
    level      = 1'b1;
    while (got < n) begin
      @(posedge clk);
      cycle++;
      if (retire_valid && retire_ready) begin
        exp_inst = prog[(pc - base_pc) >> 2];
        exp_jump = (exp_inst[6:0] == jal_op);
        assert (retire_pc == pc) else begin
          $display("Error: %0t retire_pc exp %h got %h", $time, pc, retire_pc);
          errors++;
        end
        assert (retire_inst == exp_inst) else begin
          $display("Error: %0t retire_inst exp %h got %h", $time, exp_inst, retire_inst);
          errors++;
        end
        assert (retire_jump == exp_jump) else begin
          $display("Error: %0t retire_jump exp %b got %b", $time, exp_jump, retire_jump);
          errors++;
        end
        if (check_rate && last_cycle >= 0) begin
          assert (cycle - last_cycle == mem_wait + 5) else begin
            $display("Error: %0t retire interval exp %0d got %0d", $time,
                     mem_wait + 5, cycle - last_cycle);
            errors++;
          end
        end
        last_cycle = cycle;
        pc = exp_jump ? pc + j_offset(exp_inst) : pc + 64'd4;
        got++;
        retire_count++;
      end
      if (backpressure) begin
        if (stretch == 0) begin
          level   = $random(seed) & 1;
          stretch = 1 + ($random(seed) & 7);
        end
        stretch--;
        retire_ready <= level;
      end else begin
        retire_ready <= 1'b1;
      end
    end
  endtask

  task automatic run_program(input string name, input int n, input bit backpressure,
                             input bit check_rate);
    int errors_before;
    errors_before = errors;
    apply_reset();
    collect(n, backpressure, check_rate);
    $display("test %s: %0d retires, %0d errors", name, n, errors - errors_before);
  endtask

  task automatic reset_first_pc();
    fill_straight(0);
    run_program("reset", 1, 1'b0, 1'b0);
  endtask

  task automatic straight_code();
    fill_straight(1);
    run_program("straight", 16, 1'b0, 1'b0);
  endtask

  task automatic forward_jal();
    fill_straight(2);
    // words 3 and 4 are skipped
    prog[2] = jal_word(12);
    run_program("forward_jal", 10, 1'b0, 1'b0);
  endtask

  task automatic backward_loop();
    fill_straight(3);
    prog[3] = jal_word(-8);
    run_program("backward_loop", 12, 1'b0, 1'b0);
  endtask

  task automatic random_backpressure();
    fill_straight(4);
    prog[2]  = jal_word(8);
    prog[6]  = jal_word(12);
    prog[11] = jal_word(-36);
    run_program("backpressure", 20, 1'b1, 1'b0);
  endtask

  task automatic steady_rate();
    fill_straight(5);
    run_program("rate", 16, 1'b0, 1'b1);
  endtask

  initial begin
    rst          = 1'b1;
    load_en      = 1'b0;
    load_index   = '0;
    load_data    = '0;
    retire_ready = 1'b1;
    errors       = 0;
    retire_count = 0;
    seed         = 32'he780_d2a9;
    reset_first_pc();
    straight_code();
    forward_jal();
    backward_loop();
    random_backpressure();
    steady_rate();
    $display("%0d tests, %0d retires, %0d errors", num_tests, retire_count, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // run stops here if retires stall
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: retires stopped after %0d of %0d", retire_count, total_retires);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hw/core_pkg.sv
hw/inst_mem.sv
hw/if_stage.sv
hw/id_stage.sv
hw/fetch_top.sv
verification/tb_fetch_top.sv
